//--- source/memStagePkg.sv
// Shared definitions for the memory stage. Size codes follow RV32I funct3 and the word layout is little endian
package memStagePkg;

    // ----------------------------------------------------------------------
    // Access size
    // ----------------------------------------------------------------------

    // Same encoding as funct3 of the RV32I load and store opcodes
    // Codes 3, 6 and 7 are unused and read back as zero
    typedef enum logic [2:0] {
        memByte  = 3'd0,    // LB / SB
        memHalf  = 3'd1,    // LH / SH
        memWord  = 3'd2,    // LW / SW
        memByteU = 3'd4,    // LBU
        memHalfU = 3'd5     // LHU
    } memCtrl_e;

    // ----------------------------------------------------------------------
    // RAM word views
    // ----------------------------------------------------------------------

    // One RAM word seen by the load path
    // Lane 0 sits in bits 7:0 and halfword 0 in bits 15:0
    typedef union packed {
        logic [3:0][7:0]  bytes;    // Indexed by addr[1:0]
        logic [1:0][15:0] halves;   // Indexed by addr[1]
    } memWord_u;

    // ----------------------------------------------------------------------
    // Constants
    // ----------------------------------------------------------------------

    // addi x0, x0, 0
    // Fed to decode after reset or flush so the pipeline sees a bubble
    localparam logic [31:0] nopInstr = 32'h0000_0013;

endpackage

//--- source/dataPortIf.sv
// Data port between load/store unit and RAM. No handshake and every cycle is an access
`timescale 1ns/1ps

interface dataPortIf #(
    parameter int wordAddrBits = 10     // Word address width giving 2**wordAddrBits words
);

    logic [3:0]              laneWe;    // One enable per byte lane
    logic [wordAddrBits-1:0] wordAddr;  // Byte address with the low two bits dropped
    logic [31:0]             wData;     // Store data already copied to its lanes
    logic [31:0]             rData;     // Registered old word of a read-first access

    // Load/store side drives the access
    modport unit (
        output laneWe,
        output wordAddr,
        output wData,
        input  rData
    );

    // RAM side answers it
    modport ram (
        input  laneWe,
        input  wordAddr,
        input  wData,
        output rData
    );

endinterface

//--- source/loadStoreUnit.sv
// Load/store unit. Misaligned accesses are not trapped and load data lags the address by one cycle
`timescale 1ns/1ps

module loadStoreUnit #(
    parameter int wordAddrBits = 10             // Word address width
) (
    input  logic                  CLK,
    input  logic                  RST,
    input  logic                  memWrite,     // Store this cycle
    input  memStagePkg::memCtrl_e memControl,   // Access size and signedness
    input  logic [31:0]           rwAddr,       // Byte address from the ALU
    input  logic [31:0]           wData,        // Store data in the low bits
    output logic [31:0]           rData,        // Extended load result
    dataPortIf.unit               dataPort      // To the shared RAM port A
);
    import memStagePkg::*;

    logic [3:0]  laneWe;        // Byte enables before the port
    logic [31:0] laneData;      // Store data copied across lanes
    memCtrl_e    ctrlQ;         // Size of the load in flight
    logic [1:0]  offsetQ;       // Byte offset of the load in flight
    memWord_u    ramWord;       // Returned word, two views
    logic [7:0]  byteSel;       // Byte picked by offsetQ
    logic [15:0] halfSel;       // Halfword picked by offsetQ[1]

    // ----------------------------------------------------------------------
    // Store side
    // ----------------------------------------------------------------------

    // Lane enables from size and address low bits
    always_comb begin
        laneWe = 4'b0000;
        if (memWrite) begin
            case (memControl)
                memByte, memByteU: laneWe = 4'b0001 << rwAddr[1:0];    // Single lane
                memHalf, memHalfU: laneWe = rwAddr[1] ? 4'b1100 : 4'b0011;
                memWord:           laneWe = 4'b1111;
                default:           laneWe = 4'b0000;                    // Unused code
            endcase
        end
    end

    // Copy the low byte or halfword into every lane it may land in
    always_comb begin
        case (memControl)
            memByte, memByteU: laneData = {4{wData[7:0]}};
            memHalf, memHalfU: laneData = {2{wData[15:0]}};
            default:           laneData = wData;
        endcase
    end

    assign dataPort.laneWe   = laneWe;
    assign dataPort.wordAddr = rwAddr[wordAddrBits+1:2];  // Upper address bits ignored
    assign dataPort.wData    = laneData;

    // ----------------------------------------------------------------------
    // Load side
    // ----------------------------------------------------------------------

    // Size and offset travel with the RAM read so back to back loads work
    always_ff @(posedge CLK) begin
        if (RST) begin
            ctrlQ   <= memWord;
            offsetQ <= 2'b00;
        end else begin
            ctrlQ   <= memControl;
            offsetQ <= rwAddr[1:0];
        end
    end

    assign ramWord = dataPort.rData;
    assign byteSel = ramWord.bytes[offsetQ];
    assign halfSel = ramWord.halves[offsetQ[1]];

    // Extension by the registered size
    always_comb begin
        case (ctrlQ)
            memByte:  rData = {{24{byteSel[7]}}, byteSel};     // Sign
            memByteU: rData = {24'b0, byteSel};                // Zero
            memHalf:  rData = {{16{halfSel[15]}}, halfSel};
            memHalfU: rData = {16'b0, halfSel};
            memWord:  rData = ramWord;                         // Whole word as is
            default:  rData = 32'b0;                           // Codes 3, 6, 7
        endcase
    end

    // ----------------------------------------------------------------------
    // Checks
    // ----------------------------------------------------------------------

    // A store reaches the RAM as one lane, an aligned pair or the whole word
    laneShapeChk: assert property (@(posedge CLK) disable iff (RST)
        memWrite |-> dataPort.laneWe inside {4'b0001, 4'b0010, 4'b0100, 4'b1000,
                                             4'b0011, 4'b1100, 4'b1111})
        else $error("Store lane enables %b not a legal lane set", dataPort.laneWe);

    // Halfword stores must not straddle a lane pair
    halfAlignChk: assert property (@(posedge CLK) disable iff (RST)
        (memWrite && (memControl == memHalf || memControl == memHalfU)) |-> !rwAddr[0])
        else $error("Misaligned halfword store at %h", rwAddr);

endmodule

//--- source/fetchUnit.sv
// Fetch side of the shared RAM. Assumes word-aligned PC and RAM data one cycle after the address
`timescale 1ns/1ps

module fetchUnit #(
    parameter int wordAddrBits = 10             // Word address width
) (
    input  logic                    CLK,
    input  logic                    RST,
    input  logic                    stall,      // Hold decode input
    input  logic                    flush,      // Kill the fetched word
    input  logic [31:0]             pcAddr,     // Program counter
    input  logic [31:0]             fetchWord,  // Port B read word
    output logic [wordAddrBits-1:0] fetchAddr,  // Port B word address
    output logic [31:0]             instr       // Instruction to decode
);
    import memStagePkg::*;

    logic        nopPending;    // Reset or flush seen at last edge
    logic        stallSeen;     // Stall seen at last edge
    logic [31:0] heldInstr;     // Last value shown on instr

    // Word index with the byte offset dropped
    assign fetchAddr = pcAddr[wordAddrBits+1:2];

    // ----------------------------------------------------------------------
    // Flow control state
    // ----------------------------------------------------------------------

    always_ff @(posedge CLK) begin
        if (RST) begin
            nopPending <= 1'b1;             // Bubble right after reset
            stallSeen  <= 1'b0;
        end else begin
            nopPending <= flush;
            stallSeen  <= stall & ~flush;   // Flush wins over stall
        end
    end

    // Output copy for replay while stalled
    always_ff @(posedge CLK) begin
        heldInstr <= instr;
    end

    // RAM register already gives the cycle of latency
    // The mux adds none on a normal fetch
    always_comb begin
        if (nopPending) begin
            instr = nopInstr;
        end else if (stallSeen) begin
            instr = heldInstr;              // Repeat previous word
        end else begin
            instr = fetchWord;
        end
    end

    // ----------------------------------------------------------------------
    // Checks
    // ----------------------------------------------------------------------

    // Decode gets a bubble in the cycle after a flush
    flushNopChk: assert property (@(posedge CLK) disable iff (RST)
        flush |=> instr == nopInstr)
        else $error("instr %h after flush is not a NOP", instr);

    pcAlignChk: assert property (@(posedge CLK) disable iff (RST)
        pcAddr[1:0] == 2'b00)
        else $error("Unaligned PC %h", pcAddr);

endmodule

//--- source/byteLaneRam.sv
// Dual-port RAM with byte writes on port A only. Contents start at zero in simulation only
`timescale 1ns/1ps

module byteLaneRam #(
    parameter int wordAddrBits = 10             // Depth is 2**wordAddrBits words
) (
    input  logic                    CLK,
    dataPortIf.ram                  dataPort,   // Port A for loads and stores
    input  logic [wordAddrBits-1:0] fetchAddr,  // Port B word address
    output logic [31:0]             fetchWord   // Port B registered read
);

    localparam int depth = 2 ** wordAddrBits;

    logic [31:0] mem [depth];   // Shared instruction and data store

    // ----------------------------------------------------------------------
    // Initial contents
    // ----------------------------------------------------------------------

    // Testbench fills the array through stores
    initial begin
        for (int i = 0; i < depth; i++) begin
            mem[i] = 32'b0;
        end
    end

    // ----------------------------------------------------------------------
    // Port A
    // ----------------------------------------------------------------------

    // Enabled lanes written, old word read back in the same cycle
    always @(posedge CLK) begin
        for (int lane = 0; lane < 4; lane++) begin
            if (dataPort.laneWe[lane]) begin
                mem[dataPort.wordAddr][lane*8 +: 8] <= dataPort.wData[lane*8 +: 8];
            end
        end
        dataPort.rData <= mem[dataPort.wordAddr];  // Read-first
    end

    // ----------------------------------------------------------------------
    // Port B
    // ----------------------------------------------------------------------

    // Fetch never writes
    // Same-cycle fetch of a word being stored gives an undefined result
    always_ff @(posedge CLK) begin
        fetchWord <= mem[fetchAddr];
    end

endmodule

//--- source/memStage.sv
// Memory stage top level. One unified RAM serves loads, stores and fetch with no misaligned traps or MMIO
`timescale 1ns/1ps

module memStage #(
    parameter int wordAddrBits = 10                 // 1024 words by default
) (
    input  logic                  CLK,
    input  logic                  RST,

    // Data access from execute
    input  logic                  memWrite,         // Store enable
    input  memStagePkg::memCtrl_e memControl,       // funct3 size code
    input  logic [31:0]           rwAddr,           // ALU result as byte address
    input  logic [31:0]           wData,            // rs2 store data

    // Fetch
    input  logic [31:0]           pcAddr,           // PC of the fetch stage
    input  logic                  stall,            // Hazard unit hold
    input  logic                  flush,            // Hazard unit kill

    output logic [31:0]           rData,            // Load result one cycle after the address
    output logic [31:0]           instr             // Instruction to decode
);

    logic [wordAddrBits-1:0] fetchAddr;    // Fetch unit to RAM port B
    logic [31:0]             fetchWord;    // RAM port B to fetch unit

    // ----------------------------------------------------------------------
    // Data side
    // ----------------------------------------------------------------------

    dataPortIf #(.wordAddrBits(wordAddrBits)) dataPort ();

    loadStoreUnit #(.wordAddrBits(wordAddrBits)) loadStoreUnit_i (
        .CLK        (CLK),
        .RST        (RST),
        .memWrite   (memWrite),
        .memControl (memControl),
        .rwAddr     (rwAddr),
        .wData      (wData),
        .rData      (rData),
        .dataPort   (dataPort.unit)
    );

    // ----------------------------------------------------------------------
    // Fetch side
    // ----------------------------------------------------------------------

    fetchUnit #(.wordAddrBits(wordAddrBits)) fetchUnit_i (
        .CLK        (CLK),
        .RST        (RST),
        .stall      (stall),
        .flush      (flush),
        .pcAddr     (pcAddr),
        .fetchWord  (fetchWord),
        .fetchAddr  (fetchAddr),
        .instr      (instr)
    );

    // ----------------------------------------------------------------------
    // Shared store
    // ----------------------------------------------------------------------

    // Port A data and port B fetch
    byteLaneRam #(.wordAddrBits(wordAddrBits)) byteLaneRam_i (
        .CLK        (CLK),
        .dataPort   (dataPort.ram),
        .fetchAddr  (fetchAddr),
        .fetchWord  (fetchWord)
    );

endmodule

//--- bench/memStageTb.sv
// Run from the project root so the pattern file is found. RAM depth is the 1024-word default
`timescale 1ns/1ps

module memStageTb;
    import memStagePkg::*;

    // ----------------------------------------------------------------------
    // Setup
    // ----------------------------------------------------------------------

    localparam int maxVectors = 64;                 // Room in the vector array
    localparam int clkPeriod  = 10;                 // ns
    localparam int vecBits    = 168;                // Packed width of one pattern line

    // Marks array slots that the pattern file left untouched
    localparam logic [vecBits-1:0] emptyVec = '1;

    logic        CLK;
    logic        RST;
    logic        memWrite;
    memCtrl_e    memControl;
    logic [31:0] rwAddr;
    logic [31:0] wData;
    logic [31:0] pcAddr;
    logic        stall;
    logic        flush;
    logic [31:0] rData;
    logic [31:0] instr;

    logic [vecBits-1:0] vectors [maxVectors];   // One line per cycle
    int                 numVectors;             // Lines actually loaded
    logic               loaded;                 // Vector count is valid

    memStage #(.wordAddrBits(10)) memStage_i (
        .CLK        (CLK),
        .RST        (RST),
        .memWrite   (memWrite),
        .memControl (memControl),
        .rwAddr     (rwAddr),
        .wData      (wData),
        .pcAddr     (pcAddr),
        .stall      (stall),
        .flush      (flush),
        .rData      (rData),
        .instr      (instr)
    );

    // Free running clock
    initial begin
        CLK = 1'b0;
        forever #(clkPeriod / 2) CLK = ~CLK;
    end

    // ----------------------------------------------------------------------
    // Helpers
    // ----------------------------------------------------------------------

    // Stops the run at the first difference
    task automatic checkEq(input string name, input logic [31:0] expected,
                           input logic [31:0] actual);
        if (actual !== expected) begin
            $display("Mismatch at %0d ns: %s expected %h, got %h",
                     $time, name, expected, actual);
            $display("Result: FAILED");
            $fatal(1, "Stopped on first mismatch");
        end
    endtask

    // Line layout from high bits to low
    // ctl nibble {memWrite, memControl}, rwAddr, wData, pcAddr,
    // flag nibble {chkRData, chkInstr, stall, flush}, expRData, expInstr
    task automatic driveInputs(input logic [vecBits-1:0] v);
        memWrite   = v[167];
        memControl = memCtrl_e'(v[166:164]);
        rwAddr     = v[163:132];
        wData      = v[131:100];
        pcAddr     = v[99:68];
        stall      = v[65];
        flush      = v[64];
    endtask

    // ----------------------------------------------------------------------
    // Main sequence
    // ----------------------------------------------------------------------

    initial begin
        loaded     = 1'b0;
        numVectors = 0;
        RST        = 1'b1;
        memWrite   = 1'b0;
        memControl = memWord;
        rwAddr     = 32'h0;
        wData      = 32'h0;
        pcAddr     = 32'h0;
        stall      = 1'b0;
        flush      = 1'b0;

        for (int n = 0; n < maxVectors; n++) begin
            vectors[n] = emptyVec;                  // Sentinel fill
        end
        $readmemh("bench/memStagePatterns.txt", vectors);
        for (int n = 0; n < maxVectors; n++) begin
            if (vectors[n] === emptyVec) break;     // First unused slot ends the list
            numVectors++;
        end
        loaded = 1'b1;

        if (numVectors == 0) begin
            $display("No vectors could be read from bench/memStagePatterns.txt");
            $display("Result: FAILED");
            $fatal(1, "Empty pattern file");
        end

        // Two reset edges, then a bubble must be on instr
        repeat (2) @(posedge CLK);
        #(clkPeriod / 2 - 1);
        checkEq("instr", nopInstr, instr);
        @(negedge CLK);
        RST = 1'b0;

        // Drive on the falling edge, sample shortly before the next one
        for (int n = 0; n < numVectors; n++) begin
            driveInputs(vectors[n]);
            @(posedge CLK);
            #(clkPeriod / 2 - 1);                   // Outputs settled after the edge
            if (vectors[n][67]) begin
                checkEq("rData", vectors[n][63:32], rData);
            end
            if (vectors[n][66]) begin
                checkEq("instr", vectors[n][31:0], instr);
            end
            @(negedge CLK);
        end

        $display("Result: PASSED");
        $finish;
    end

    // ----------------------------------------------------------------------
    // Watchdog
    // ----------------------------------------------------------------------

    // Budget is the vector run plus slack for reset
    initial begin
        wait (loaded);
        #((numVectors + 20) * clkPeriod);
        $display("Timeout: the vector run took longer than its expected length");
        $display("Result: FAILED");
        $fatal(1, "Watchdog expired");
    end

endmodule

//--- bench/memStagePatterns.txt
// ctl{memWrite,memControl}_rwAddr_wData_pcAddr_flags{chkR,chkI,stall,flush}_expRData_expInstr
// Expected values are the outputs after the rising edge that ends the cycle of the line
a_00000000_00500093_00000200_c_00000000_00000000
a_00000004_00a00113_00000200_c_00000000_00000000
a_00000008_002081b3_00000200_c_00000000_00000000
a_0000000c_00312023_00000200_c_00000000_00000000
a_00000100_deadbeef_00000200_c_00000000_00000000
a_00000104_cafe8001_00000200_c_00000000_00000000
a_00000108_12345678_00000200_c_00000000_00000000
2_00000100_00000000_00000200_c_deadbeef_00000000
2_00000104_00000000_00000200_c_cafe8001_00000000
2_00000108_00000000_00000200_c_12345678_00000000
a_00000100_0badf00d_00000200_c_deadbeef_00000000
2_00000100_00000000_00000200_c_0badf00d_00000000
8_00000109_777777a5_00000200_c_00000056_00000000
9_0000010a_5555c3e1_00000200_c_00001234_00000000
2_00000108_00000000_00000200_c_c3e1a578_00000000
8_00000107_0000009f_00000200_c_ffffffca_00000000
9_00000104_00007c2d_00000200_c_ffff8001_00000000
2_00000104_00000000_00000200_c_9ffe7c2d_00000000
a_0000010c_f18293a4_00000200_c_00000000_00000000
0_0000010c_00000000_00000200_c_ffffffa4_00000000
0_0000010d_00000000_00000200_c_ffffff93_00000000
0_0000010e_00000000_00000200_c_ffffff82_00000000
0_0000010f_00000000_00000200_c_fffffff1_00000000
4_0000010c_00000000_00000200_c_000000a4_00000000
4_0000010d_00000000_00000200_c_00000093_00000000
4_0000010e_00000000_00000200_c_00000082_00000000
4_0000010f_00000000_00000200_c_000000f1_00000000
1_0000010c_00000000_00000200_c_ffff93a4_00000000
1_0000010e_00000000_00000200_c_fffff182_00000000
5_0000010c_00000000_00000200_c_000093a4_00000000
5_0000010e_00000000_00000200_c_0000f182_00000000
3_0000010c_00000000_00000200_c_00000000_00000000
6_00000100_00000000_00000200_c_00000000_00000000
7_00000104_00000000_00000200_c_00000000_00000000
2_00000000_00000000_00000000_4_00000000_00500093
2_00000000_00000000_00000004_4_00000000_00a00113
2_00000000_00000000_00000008_6_00000000_00a00113
2_00000000_00000000_0000000c_6_00000000_00a00113
2_00000000_00000000_00000008_4_00000000_002081b3
2_00000000_00000000_0000000c_5_00000000_00000013
2_00000000_00000000_0000000c_4_00000000_00312023
2_00000000_00000000_00000000_4_00000000_00500093
2_00000000_00000000_00000004_7_00000000_00000013
2_00000000_00000000_00000008_6_00000000_00000013
2_00000000_00000000_00000008_4_00000000_002081b3
2_00000000_00000000_00000100_4_00000000_0badf00d

//--- build.f
source/memStagePkg.sv
source/dataPortIf.sv
source/loadStoreUnit.sv
source/fetchUnit.sv
source/byteLaneRam.sv
source/memStage.sv
bench/memStageTb.sv

//--- Makefile
# Verilator build and run of the memory stage testbench
TOP := memStageTb

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -Mdir obj_dir -f build.f
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -q "Result: PASSED"

clean:
	rm -rf obj_dir
